//--- logic/load_pkg.sv
// Download index encoding and configuration memory map
// for the VIC-20 image loader

package load_pkg;

	// Host download index, seen as one code or as kind and slot
	typedef union packed {
		logic [7:0] code;
		struct packed {
			logic [1:0] kind;
			logic [5:0] slot;
		} f;
	} dl_index_u;

	// Whole-byte index codes
	localparam logic [7:0] IDX_PRG = 8'h01;
	localparam logic [7:0] IDX_CRT = 8'h41;
	localparam logic [7:0] IDX_CT  = 8'h81;
	localparam logic [7:0] IDX_TAP = 8'hC1;
	localparam logic [7:0] IDX_ROM = 8'h06;

	localparam int CONF_ADDR_W = 16;

	// Load limits
	localparam logic [CONF_ADDR_W-1:0] PRG_LIMIT  = 16'hA000;
	localparam logic [CONF_ADDR_W-1:0] CART_LIMIT = 16'hC000;

	// Kernal window inside the ROM file and its relocation
	localparam logic [CONF_ADDR_W-1:0] ROM_WIN_LO = 16'h4000;
	localparam logic [CONF_ADDR_W-1:0] ROM_WIN_HI = 16'h8000;
	localparam logic [CONF_ADDR_W-1:0] ROM_RELOC  = 16'h8000;

	// BASIC start/end pointers, low byte on even entries
	localparam logic [0:7][CONF_ADDR_W-1:0] BASIC_PTR_ADDR = {
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h00AE, 16'h00AF
	};

	// Expansion blocks 0,1,2,3 and 5 of the 8K map
	localparam int NUM_BLK = 5;

endpackage

//--- logic/tape_pkg.sv
// TAP image layout constants and tape field widths

package tape_pkg;

	// Version byte position in the TAP header
	localparam int TAP_VER_OFFSET = 'h0C;

	// Deck FIFO checks early, so fetch a little past the end
	localparam int TAP_TAIL = 2;

	localparam int TAP_VER_W = 2;

	typedef logic [TAP_VER_W-1:0] tap_ver_t;

endpackage

//--- logic/basic_ptr_patch.sv
// BASIC pointer patch sequencer
// Writes the end of a loaded program into the eight BASIC pointers
`timescale 1ns/1ps

module basic_ptr_patch import load_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   start,
	input  logic [CONF_ADDR_W-1:0] end_addr,
	output logic [CONF_ADDR_W-1:0] ptr_addr,
	output logic [7:0]             ptr_data,
	output logic                   ptr_wr,
	output logic                   busy
);

	// Step 0 is idle, odd steps write, even steps are gaps
	logic [3:0] step;
	logic [2:0] entry;

	assign entry = step[3:1];
	assign busy  = (step != 4'd0) | ptr_wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			step   <= 4'd0;
			ptr_wr <= 1'b0;
		end else begin
			ptr_wr <= step[0];
			if (start) begin
				step <= 4'd1;
			end else if (step != 4'd0) begin
				// Wraps to idle after the last entry
				step <= step + 4'd1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (step[0]) begin
			ptr_addr <= BASIC_PTR_ADDR[entry];
			ptr_data <= entry[0] ? end_addr[15:8] : end_addr[7:0];
		end
	end

	// Writes stay spaced so the core sees each one separately
	a_ptr_wr_spaced: assert property (
		@(posedge clk_sys) disable iff (reset)
		ptr_wr |=> !ptr_wr
	);

endmodule

//--- logic/image_loader.sv
// PRG, Kernal ROM and cartridge stream decoder with
// cartridge block tracking and expansion masks
`timescale 1ns/1ps

module image_loader import load_pkg::*; #(
	parameter int TAPE_ADDR_W = 25
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  dl_index_u              dl_index,
	input  logic [TAPE_ADDR_W-1:0] dl_addr,
	input  logic [7:0]             dl_data,
	input  logic [7:0]             dl_ext,
	input  logic [NUM_BLK-1:0]     ram_ext_sel,
	input  logic                   cart_writable,
	input  logic                   cart_detach,
	output logic [CONF_ADDR_W-1:0] conf_addr,
	output logic [7:0]             conf_data,
	output logic                   conf_wr,
	output logic                   cart_reset,
	output logic [NUM_BLK-1:0]     ram_ext_en,
	output logic [NUM_BLK-1:0]     ram_ext_ro
);

	logic load_prg;
	logic load_crt;
	logic load_ct;
	logic load_rom;
	logic old_active;
	logic patch_start;
	logic [CONF_ADDR_W-1:0] load_addr;
	logic [NUM_BLK-1:0]     cart_blk;

	logic [CONF_ADDR_W-1:0] ptr_addr;
	logic [7:0]             ptr_data;
	logic                   ptr_wr;
	logic                   patch_busy;

	assign load_prg = dl_index.code == IDX_PRG;
	assign load_crt = dl_index.code == IDX_CRT;
	assign load_ct  = dl_index.code == IDX_CT;
	assign load_rom = dl_index.code == IDX_ROM;

	// First idle cycle after a PRG download
	assign patch_start = old_active & ~dl_active & load_prg;

	basic_ptr_patch patch_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.start    (patch_start),
		.end_addr (load_addr),
		.ptr_addr (ptr_addr),
		.ptr_data (ptr_data),
		.ptr_wr   (ptr_wr),
		.busy     (patch_busy)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stream decode

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_active <= 1'b0;
			conf_wr    <= 1'b0;
			cart_reset <= 1'b0;
			cart_blk   <= '0;
		end else begin
			old_active <= dl_active;
			conf_wr    <= 1'b0;

			if (patch_busy) begin
				conf_wr   <= ptr_wr;
				conf_addr <= ptr_addr;
				conf_data <= ptr_data;
			end else if (dl_active && dl_wr) begin
				if (load_prg) begin
					if (dl_addr == 0) begin
						load_addr[7:0] <= dl_data;
					end else if (dl_addr == 1) begin
						load_addr[15:8] <= dl_data;
					end else if (load_addr < PRG_LIMIT) begin
						conf_addr <= load_addr;
						conf_data <= dl_data;
						conf_wr   <= 1'b1;
						load_addr <= load_addr + 16'd1;
					end
				end

				// Kernal lives in the second half of the ROM file
				if (load_rom && dl_addr >= ROM_WIN_LO && dl_addr < ROM_WIN_HI) begin
					conf_addr <= dl_addr[15:0] + ROM_RELOC;
					conf_data <= dl_data;
					conf_wr   <= 1'b1;
				end

				if (load_crt || load_ct) begin
					if (load_crt && dl_addr == 0) begin
						load_addr[7:0] <= dl_data;
					end else if (load_crt && dl_addr == 1) begin
						load_addr[15:8] <= dl_data;
					end else if (load_addr < CART_LIMIT) begin
						case (load_addr[15:13])
							3'd0: cart_blk[0] <= 1'b1;
							3'd1: cart_blk[1] <= 1'b1;
							3'd2: cart_blk[2] <= 1'b1;
							3'd3: cart_blk[3] <= 1'b1;
							3'd5: cart_blk[4] <= 1'b1;
							default: ;
						endcase
						conf_addr <= load_addr;
						conf_data <= dl_data;
						conf_wr   <= 1'b1;
						load_addr <= load_addr + 16'd1;
					end
				end
			end

			// Raw cartridge base from the extension digit
			if (~old_active && dl_active && load_ct) begin
				if (dl_ext >= "2" && dl_ext <= "9") begin
					load_addr <= {dl_ext[3:0], 12'h000};
				end
				if (dl_ext >= "A" && dl_ext <= "B") begin
					load_addr <= {dl_ext[3:0] + 4'd9, 12'h000};
				end
			end

			// Core held in reset for the length of a CRT download
			if ((old_active ^ dl_active) && load_crt) begin
				cart_reset <= dl_active;
			end

			if (cart_detach) begin
				cart_blk   <= '0;
				cart_reset <= 1'b0;
			end
		end
	end

	// Cartridge blocks act as ROM unless marked writable
	assign ram_ext_en = ram_ext_sel | cart_blk;
	assign ram_ext_ro = cart_writable ? '0 : cart_blk;

endmodule

//--- logic/tape_buffer.sv
// TAP image store and playback fetch
// Single Wishbone classic master shared by download and playback
`timescale 1ns/1ps

module tape_buffer import load_pkg::*; import tape_pkg::*; #(
	parameter int TAPE_ADDR_W = 25
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  dl_index_u              dl_index,
	input  logic [TAPE_ADDR_W-1:0] dl_addr,
	input  logic [7:0]             dl_data,
	input  logic                   tape_restart,
	input  logic                   tape_fifo_full,
	input  logic [7:0]             wb_dat_r,
	input  logic                   wb_ack,
	output logic                   dl_wait,
	output logic [7:0]             tape_byte,
	output logic                   tape_byte_wr,
	output tap_ver_t               tape_version,
	output logic                   tape_loaded,
	output logic                   wb_cyc,
	output logic                   wb_stb,
	output logic                   wb_we,
	output logic [TAPE_ADDR_W-1:0] wb_adr,
	output logic [7:0]             wb_dat_w
);

	logic tap_dl;
	logic play_rst;
	logic wr_req;
	logic byte_pend;
	logic [TAPE_ADDR_W-1:0] wr_adr;
	logic [7:0]             wr_dat;
	logic [TAPE_ADDR_W-1:0] play_ptr;
	logic [TAPE_ADDR_W-1:0] end_ptr;

	// TAP is kind 3, slot 1
	assign tap_dl = dl_active && dl_index.f.kind == IDX_TAP[7:6]
		&& dl_index.f.slot == IDX_TAP[5:0];
	assign play_rst = reset | tap_dl | tape_restart;

	assign tape_loaded  = play_ptr < end_ptr;
	// Fetched byte waits here while the deck FIFO is full
	assign tape_byte_wr = byte_pend & ~tape_fifo_full;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wait   <= 1'b0;
			wr_req    <= 1'b0;
			byte_pend <= 1'b0;
			wb_cyc    <= 1'b0;
			wb_stb    <= 1'b0;
		end else begin
			if (tape_byte_wr) begin
				byte_pend <= 1'b0;
			end

			// Host stalls until its byte is in memory
			if (tap_dl && dl_wr) begin
				wr_req  <= 1'b1;
				dl_wait <= 1'b1;
				wr_adr  <= dl_addr;
				wr_dat  <= dl_data;
				if (dl_addr == TAPE_ADDR_W'(TAP_VER_OFFSET)) begin
					tape_version <= dl_data[TAP_VER_W-1:0];
				end
			end

			if (wb_cyc) begin
				if (wb_ack) begin
					wb_cyc <= 1'b0;
					wb_stb <= 1'b0;
					if (wb_we) begin
						dl_wait <= 1'b0;
					end else if (!play_rst) begin
						tape_byte <= wb_dat_r;
						byte_pend <= 1'b1;
					end
				end
			end else if (wr_req) begin
				wr_req   <= 1'b0;
				wb_cyc   <= 1'b1;
				wb_stb   <= 1'b1;
				wb_we    <= 1'b1;
				wb_adr   <= wr_adr;
				wb_dat_w <= wr_dat;
			end else if (!play_rst && tape_loaded && !tape_fifo_full && !byte_pend) begin
				wb_cyc <= 1'b1;
				wb_stb <= 1'b1;
				wb_we  <= 1'b0;
				wb_adr <= play_ptr;
			end

			if (play_rst) begin
				byte_pend <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Playback pointers

	always_ff @(posedge clk_sys) begin
		if (play_rst) begin
			play_ptr <= '0;
			// End pointer counts the file length plus the tail
			if (!tap_dl) begin
				end_ptr <= '0;
			end else if (dl_wr) begin
				end_ptr <= dl_addr + TAPE_ADDR_W'(TAP_TAIL + 1);
			end
		end else if (wb_cyc && wb_ack && !wb_we) begin
			play_ptr <= play_ptr + 1'b1;
		end
	end

	a_stb_in_cyc: assert property (
		@(posedge clk_sys) disable iff (reset)
		wb_stb |-> wb_cyc
	);

	// Request held steady until the slave answers
	a_req_stable: assert property (
		@(posedge clk_sys) disable iff (reset)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_we))
	);

endmodule

//--- logic/vic_loader_top.sv
// VIC-20 loading logic top level
// Image loader and tape buffer side by side on the host stream
`timescale 1ns/1ps

module vic_loader_top import load_pkg::*; import tape_pkg::*; #(
	parameter int TAPE_ADDR_W = 25
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  dl_index_u              dl_index,
	input  logic [TAPE_ADDR_W-1:0] dl_addr,
	input  logic [7:0]             dl_data,
	input  logic                   dl_wr,
	input  logic [7:0]             dl_ext,
	output logic                   dl_wait,
	input  logic [NUM_BLK-1:0]     ram_ext_sel,
	input  logic                   cart_writable,
	input  logic                   cart_detach,
	output logic [CONF_ADDR_W-1:0] conf_addr,
	output logic [7:0]             conf_data,
	output logic                   conf_wr,
	output logic                   cart_reset,
	output logic [NUM_BLK-1:0]     ram_ext_en,
	output logic [NUM_BLK-1:0]     ram_ext_ro,
	input  logic                   tape_restart,
	input  logic                   tape_fifo_full,
	output logic [7:0]             tape_byte,
	output logic                   tape_byte_wr,
	output tap_ver_t               tape_version,
	output logic                   tape_loaded,
	output logic                   wb_cyc,
	output logic                   wb_stb,
	output logic                   wb_we,
	output logic [TAPE_ADDR_W-1:0] wb_adr,
	output logic [7:0]             wb_dat_w,
	input  logic [7:0]             wb_dat_r,
	input  logic                   wb_ack
);

	image_loader #(.TAPE_ADDR_W(TAPE_ADDR_W)) loader_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_active     (dl_active),
		.dl_wr         (dl_wr),
		.dl_index      (dl_index),
		.dl_addr       (dl_addr),
		.dl_data       (dl_data),
		.dl_ext        (dl_ext),
		.ram_ext_sel   (ram_ext_sel),
		.cart_writable (cart_writable),
		.cart_detach   (cart_detach),
		.conf_addr     (conf_addr),
		.conf_data     (conf_data),
		.conf_wr       (conf_wr),
		.cart_reset    (cart_reset),
		.ram_ext_en    (ram_ext_en),
		.ram_ext_ro    (ram_ext_ro)
	);

	tape_buffer #(.TAPE_ADDR_W(TAPE_ADDR_W)) tape_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.dl_active      (dl_active),
		.dl_wr          (dl_wr),
		.dl_index       (dl_index),
		.dl_addr        (dl_addr),
		.dl_data        (dl_data),
		.tape_restart   (tape_restart),
		.tape_fifo_full (tape_fifo_full),
		.wb_dat_r       (wb_dat_r),
		.wb_ack         (wb_ack),
		.dl_wait        (dl_wait),
		.tape_byte      (tape_byte),
		.tape_byte_wr   (tape_byte_wr),
		.tape_version   (tape_version),
		.tape_loaded    (tape_loaded),
		.wb_cyc         (wb_cyc),
		.wb_stb         (wb_stb),
		.wb_we          (wb_we),
		.wb_adr         (wb_adr),
		.wb_dat_w       (wb_dat_w)
	);

endmodule

//--- verif/wb_mem_model.sv
// Wishbone classic slave memory with a random acknowledge delay
// Unwritten locations hold an address-derived fill pattern
`timescale 1ns/1ps

module wb_mem_model #(
	parameter int ADDR_W = 25,
	parameter int DEPTH  = 256
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [ADDR_W-1:0] wb_adr,
	input  logic [7:0]        wb_dat_w,
	output logic [7:0]        wb_dat_r,
	output logic              wb_ack
);

	logic [7:0] mem [0:DEPTH-1];
	logic       busy;
	logic [1:0] wait_cnt;

	// Fill mixes every index bit into the byte
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = 8'(i * 37 + (i >> 4) * 11) ^ 8'h5A;
		end
	end

	always @(posedge clk_sys) begin
		if (reset) begin
			wb_ack   <= 1'b0;
			busy     <= 1'b0;
			wait_cnt <= 2'd0;
			wb_dat_r <= 8'h00;
		end else if (wb_ack) begin
			// Master drops its strobes on this edge
			wb_ack <= 1'b0;
			busy   <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!busy) begin
				busy     <= 1'b1;
				wait_cnt <= 2'($urandom_range(0, 3));
			end else if (wait_cnt == 2'd0) begin
				wb_ack <= 1'b1;
				if (wb_we) begin
					mem[wb_adr % DEPTH] <= wb_dat_w;
				end else begin
					wb_dat_r <= mem[wb_adr % DEPTH];
				end
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

endmodule

//--- verif/vic_loader_tb.sv
// Testbench for the VIC-20 loading logic
// Streams PRG, ROM, cartridge and TAP files and checks the responses
`timescale 1ns/1ps

module vic_loader_tb
	import load_pkg::*;
	import tape_pkg::*;
();

	localparam int ADDR_W  = 25;
	localparam int PRG_LEN = 40;
	localparam int ROM_LEN = 33;
	localparam int CRT_LEN = 24;
	localparam int CT_LEN  = 16;
	localparam int TAP_LEN = 64;
	localparam int CYCLE_LIMIT =
		2 * (PRG_LEN + ROM_LEN + CRT_LEN + CT_LEN + TAP_LEN) + 2000;

	logic              clk_sys;
	logic              reset;
	logic              dl_active;
	dl_index_u         dl_index;
	logic [ADDR_W-1:0] dl_addr;
	logic [7:0]        dl_data;
	logic              dl_wr;
	logic [7:0]        dl_ext;
	logic              dl_wait;
	logic [4:0]        ram_ext_sel;
	logic              cart_writable;
	logic              cart_detach;
	logic [15:0]       conf_addr;
	logic [7:0]        conf_data;
	logic              conf_wr;
	logic              cart_reset;
	logic [4:0]        ram_ext_en;
	logic [4:0]        ram_ext_ro;
	logic              tape_restart;
	logic              tape_fifo_full;
	logic [7:0]        tape_byte;
	logic              tape_byte_wr;
	tap_ver_t          tape_version;
	logic              tape_loaded;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	logic [ADDR_W-1:0] wb_adr;
	logic [7:0]        wb_dat_w;
	logic [7:0]        wb_dat_r;
	logic              wb_ack;

	logic [7:0]  file_buf [0:255];
	logic [23:0] conf_exp [$];
	logic [7:0]  tape_exp [$];
	logic [15:0] ptr_tab [0:7];
	int          err_cnt;
	int          test_cnt;
	int          test_err_base;
	int          cycles;
	logic        check_creset;
	logic        fifo_rand;

	vic_loader_top #(.TAPE_ADDR_W(ADDR_W)) vic_loader_top_i (.*);

	wb_mem_model #(.ADDR_W(ADDR_W)) mem_i (.*);

	always #20 clk_sys = ~clk_sys;

	task automatic fail(input string msg);
		$display("%s", msg);
		err_cnt++;
	endtask

	task automatic mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
		$display("MISMATCH %s expected %h got %h", sig, exp, got);
		err_cnt++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checkers

	always @(posedge clk_sys) begin : conf_check
		logic [23:0] exp;
		if (!reset && conf_wr) begin
			if (conf_exp.size() == 0) begin
				fail($sformatf("Unexpected conf write to address %h", conf_addr));
			end else begin
				exp = conf_exp.pop_front();
				assert (conf_addr == exp[23:8]) else mismatch("conf_addr", exp[23:8], conf_addr);
				assert (conf_data == exp[7:0]) else mismatch("conf_data", exp[7:0], conf_data);
			end
		end
	end

	always @(posedge clk_sys) begin : tape_check
		logic [7:0] exp;
		if (!reset && tape_byte_wr) begin
			assert (!tape_fifo_full) else fail("Tape byte written while deck FIFO full");
			if (tape_exp.size() == 0) begin
				fail($sformatf("Unexpected tape byte %h", tape_byte));
			end else begin
				exp = tape_exp.pop_front();
				assert (tape_byte == exp) else mismatch("tape_byte", exp, tape_byte);
			end
		end
	end

	a_wb_stb_cyc: assert property (@(posedge clk_sys) disable iff (reset)
		wb_stb |-> wb_cyc)
		else fail("Wishbone strobe high outside a cycle");

	a_wb_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(wb_stb && !wb_ack) |=> (wb_stb && wb_cyc && $stable(wb_adr)
			&& $stable(wb_we) && $stable(wb_dat_w)))
		else fail("Wishbone request changed before acknowledge");

	a_wb_drop: assert property (@(posedge clk_sys) disable iff (reset)
		(wb_stb && wb_ack) |=> (!wb_stb && !wb_cyc))
		else fail("Wishbone strobes not dropped after acknowledge");

	a_cart_reset: assert property (@(posedge clk_sys) disable iff (reset)
		check_creset |-> cart_reset)
		else fail("Cartridge reset low during cartridge download");

	// Random deck back-pressure during playback
	always @(negedge clk_sys) begin
		if (fifo_rand) begin
			tape_fifo_full = ($urandom_range(0, 2) == 0);
		end else begin
			tape_fifo_full = 1'b0;
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped at the cycle limit, a test did not finish");
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic stream_file(input logic [7:0] idx, input logic [7:0] ext,
		input logic [ADDR_W-1:0] base, input int len, input logic crt);
		int gap;
		@(negedge clk_sys);
		dl_index  = idx;
		dl_ext    = ext;
		dl_active = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_creset = crt;
		for (int i = 0; i < len; i++) begin
			gap = $urandom_range(0, 2);
			repeat (gap) @(negedge clk_sys);
			dl_addr = base + ADDR_W'(i);
			dl_data = file_buf[i];
			dl_wr   = 1'b1;
			@(negedge clk_sys);
			dl_wr = 1'b0;
			while (dl_wait) @(negedge clk_sys);
		end
		@(negedge clk_sys);
		check_creset = 1'b0;
		dl_active    = 1'b0;
	endtask

	task automatic wait_conf_drained();
		while (conf_exp.size() != 0) @(negedge clk_sys);
		repeat (6) @(negedge clk_sys);
	endtask

	task automatic check_masks(input logic [4:0] blk);
		for (int k = 0; k < 2; k++) begin
			@(negedge clk_sys);
			ram_ext_sel   = 5'($urandom);
			cart_writable = k[0];
			@(posedge clk_sys);
			assert (ram_ext_en == (ram_ext_sel | blk))
				else mismatch("ram_ext_en", ram_ext_sel | blk, ram_ext_en);
			assert (ram_ext_ro == (k[0] ? 5'd0 : blk))
				else mismatch("ram_ext_ro", k[0] ? 5'd0 : blk, ram_ext_ro);
		end
		@(negedge clk_sys);
		cart_writable = 1'b0;
	endtask

	task automatic end_test(input string name);
		if (conf_exp.size() != 0) begin
			fail($sformatf("%0d expected conf writes never arrived", conf_exp.size()));
			conf_exp.delete();
		end
		if (tape_exp.size() != 0) begin
			fail($sformatf("%0d expected tape bytes never arrived", tape_exp.size()));
			tape_exp.delete();
		end
		$display("Test %0s finished with %0d errors", name, err_cnt - test_err_base);
		test_cnt++;
		test_err_base = err_cnt;
	endtask

	initial begin
		logic [15:0] na;
		void'($urandom(10291));
		clk_sys = 1'b0;
		reset = 1'b1;
		dl_active = 1'b0;
		dl_index = 8'h00;
		dl_addr = '0;
		dl_data = 8'h00;
		dl_wr = 1'b0;
		dl_ext = 8'h00;
		ram_ext_sel = 5'd0;
		cart_writable = 1'b0;
		cart_detach = 1'b0;
		tape_restart = 1'b0;
		tape_fifo_full = 1'b0;
		check_creset = 1'b0;
		fifo_rand = 1'b0;
		err_cnt = 0;
		test_cnt = 0;
		test_err_base = 0;
		cycles = 0;
		ptr_tab = '{16'h002D, 16'h002E, 16'h002F, 16'h0030,
			16'h0031, 16'h0032, 16'h00AE, 16'h00AF};
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;

		@(negedge clk_sys);
		assert (!conf_wr && !wb_cyc && !wb_stb && !dl_wait && !tape_byte_wr && !cart_reset)
			else fail("Control output high after reset");
		assert (ram_ext_en == 5'd0 && !tape_loaded)
			else fail("Block flags or tape pointers not cleared by reset");
		end_test("reset state");

		// PRG at 9FF0 stops at A000 and is followed by the pointer patch
		for (int i = 0; i < PRG_LEN; i++) file_buf[i] = 8'($urandom);
		file_buf[0] = 8'hF0;
		file_buf[1] = 8'h9F;
		na = 16'h9FF0;
		for (int i = 2; i < PRG_LEN; i++) begin
			if (na < 16'hA000) begin
				conf_exp.push_back({na, file_buf[i]});
				na++;
			end
		end
		for (int k = 0; k < 8; k++) begin
			conf_exp.push_back({ptr_tab[k], k[0] ? na[15:8] : na[7:0]});
		end
		stream_file(IDX_PRG, 8'h00, '0, PRG_LEN, 1'b0);
		wait_conf_drained();
		end_test("PRG load and pointer patch");

		// Only the Kernal window is written, relocated by 8000
		for (int i = 0; i < ROM_LEN; i++) begin
			file_buf[i] = 8'($urandom);
			if (16'h3FF0 + i >= 16'h4000) begin
				conf_exp.push_back({16'(16'h3FF0 + i + 16'h8000), file_buf[i]});
			end
		end
		stream_file(IDX_ROM, 8'h00, ADDR_W'('h3FF0), ROM_LEN, 1'b0);
		wait_conf_drained();
		end_test("Kernal ROM");

		for (int i = 0; i < CRT_LEN; i++) file_buf[i] = 8'($urandom);
		file_buf[0] = 8'h00;
		file_buf[1] = 8'h60;
		for (int i = 2; i < CRT_LEN; i++) begin
			conf_exp.push_back({16'(16'h6000 + i - 2), file_buf[i]});
		end
		stream_file(IDX_CRT, 8'h00, '0, CRT_LEN, 1'b1);
		wait_conf_drained();
		assert (!cart_reset) else fail("Cartridge reset still high after download");
		check_masks(5'b01000);
		end_test("CRT cartridge");

		for (int i = 0; i < CT_LEN; i++) begin
			file_buf[i] = 8'($urandom);
			conf_exp.push_back({16'(16'hA000 + i), file_buf[i]});
		end
		stream_file(IDX_CT, "A", '0, CT_LEN, 1'b0);
		wait_conf_drained();
		check_masks(5'b11000);
		end_test("CT cartridge");

		// Detach while a cartridge download holds the core in reset
		@(negedge clk_sys);
		dl_index  = IDX_CRT;
		dl_active = 1'b1;
		repeat (2) @(negedge clk_sys);
		assert (cart_reset) else fail("Cartridge reset low during cartridge download");
		cart_detach = 1'b1;
		@(negedge clk_sys);
		cart_detach = 1'b0;
		assert (!cart_reset) else fail("Cartridge reset high after detach");
		check_masks(5'b00000);
		@(negedge clk_sys);
		dl_active = 1'b0;
		end_test("cartridge detach");

		// Tail bytes come from untouched memory past the file
		for (int i = 0; i < TAP_LEN; i++) begin
			file_buf[i] = 8'($urandom);
			tape_exp.push_back(file_buf[i]);
		end
		for (int i = 0; i < TAP_TAIL; i++) tape_exp.push_back(mem_i.mem[TAP_LEN + i]);
		fifo_rand = 1'b1;
		stream_file(IDX_TAP, 8'h00, '0, TAP_LEN, 1'b0);
		while (tape_exp.size() != 0) @(negedge clk_sys);
		repeat (4) @(negedge clk_sys);
		fifo_rand = 1'b0;
		assert (!tape_loaded) else fail("Tape still loaded after playback end");
		assert (tape_version == file_buf[12][1:0])
			else mismatch("tape_version", file_buf[12][1:0], tape_version);
		for (int i = 0; i < TAP_LEN; i++) begin
			assert (mem_i.mem[i] == file_buf[i])
				else mismatch($sformatf("mem[%0d]", i), file_buf[i], mem_i.mem[i]);
		end
		end_test("tape buffer");

		$display("Tests run %0d, errors %0d", test_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
logic/load_pkg.sv
logic/tape_pkg.sv
logic/basic_ptr_patch.sv
logic/image_loader.sv
logic/tape_buffer.sv
logic/vic_loader_top.sv
verif/wb_mem_model.sv
verif/vic_loader_tb.sv
